// ==== Makefile ====
TOP = tb_connect_four

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== common/c4_board_pkg.sv ====
`default_nettype none

package c4_board_pkg;

    // Board geometry, row 0 at the bottom
    localparam int ROWS = 8;
    localparam int COLS = 8;

    localparam int ROW_BITS = 3;
    localparam int COL_BITS = 3;

    // Fill level runs from 0 to ROWS, one bit wider than a row index
    localparam int LEVEL_BITS = 4;

    localparam int WIN_LEN = 4;

    // Cell contents, the two piece codes double as player codes
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'b00,
        CELL_P1    = 2'b01,
        CELL_P2    = 2'b10
    } cell_t;

    // Indexed [row][col]
    typedef cell_t [ROWS-1:0][COLS-1:0] board_t;

    typedef logic [ROWS-1:0][COLS-1:0] mask_t;

endpackage

`default_nettype wire

// ==== common/c4_game_pkg.sv ====
`default_nettype none

package c4_game_pkg;

    typedef enum logic [1:0] {
        GS_IDLE  = 2'd0,
        GS_PLACE = 2'd1,
        GS_SCAN  = 2'd2,
        GS_OVER  = 2'd3
    } game_state_t;

    // Scan order of the windows through the new piece
    // Window k of a group has the piece at position k of the line
    typedef enum logic [3:0] {
        SW_DOWN   = 4'd0,
        SW_ROW_1  = 4'd1,
        SW_ROW_2  = 4'd2,
        SW_ROW_3  = 4'd3,
        SW_ROW_4  = 4'd4,
        SW_RISE_1 = 4'd5,
        SW_RISE_2 = 4'd6,
        SW_RISE_3 = 4'd7,
        SW_RISE_4 = 4'd8,
        SW_FALL_1 = 4'd9,
        SW_FALL_2 = 4'd10,
        SW_FALL_3 = 4'd11,
        SW_FALL_4 = 4'd12
    } scan_win_t;

endpackage

`default_nettype wire

// ==== compile.f ====
common/c4_board_pkg.sv
common/c4_game_pkg.sv
design/c4_button_edge.sv
design/c4_board_store.sv
design/c4_flash_display.sv
win_check/c4_win_scan.sv
design/c4_game_ctrl.sv
design/connect_four_top.sv
test/c4_ctrl_chk.sv
test/tb_connect_four.sv

// ==== design/c4_board_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module c4_board_store
    import c4_board_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                place,
    input  logic [COL_BITS-1:0] cursor,
    input  cell_t               player,
    input  logic                mark,
    input  mask_t               mark_cells,
    output logic                column_full,
    output logic [ROW_BITS-1:0] last_row,
    output board_t              board,
    output mask_t               win_mask
);

    logic [COLS-1:0][LEVEL_BITS-1:0] levels;
    logic [LEVEL_BITS-1:0] cur_level;
    logic [ROW_BITS-1:0] fill_row;

    assign cur_level   = levels[cursor];
    assign fill_row    = cur_level[ROW_BITS-1:0];
    assign column_full = (cur_level == LEVEL_BITS'(ROWS));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int r = 0; r < ROWS; r++)
            begin
                for (int c = 0; c < COLS; c++)
                begin
                    board[r][c] <= CELL_EMPTY;
                end
            end
            levels   <= '0;
            win_mask <= '0;
        end
        else
        begin
            // The controller only places into a column with room left
            if (place)
            begin
                board[fill_row][cursor] <= player;
                levels[cursor]          <= cur_level + 1'b1;
            end
            if (mark)
            begin
                win_mask <= win_mask | mark_cells;
            end
        end
    end

    // Row of the newest piece, read by the scanner
    always_ff @(posedge clk)
    begin
        if (place)
        begin
            last_row <= fill_row;
        end
    end

endmodule

`default_nettype wire

// ==== design/c4_button_edge.sv ====
`timescale 1ns/1ps
`default_nettype none

module c4_button_edge (
    input  logic clk,
    input  logic rst_n,
    input  logic move_left,
    input  logic move_right,
    input  logic drop_piece,
    output logic press_left,
    output logic press_right,
    output logic press_drop
);

    logic [2:0] left_sync;
    logic [2:0] right_sync;
    logic [2:0] drop_sync;

    logic left_fall;
    logic right_fall;

    // Buttons idle high, so the chains reset to ones
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            left_sync  <= 3'b111;
            right_sync <= 3'b111;
            drop_sync  <= 3'b111;
        end
        else
        begin
            left_sync  <= {left_sync[1:0], move_left};
            right_sync <= {right_sync[1:0], move_right};
            drop_sync  <= {drop_sync[1:0], drop_piece};
        end
    end

    // A press is a high to low step of the synchronized level
    assign left_fall  = left_sync[2] & ~left_sync[1];
    assign right_fall = right_sync[2] & ~right_sync[1];
    assign press_drop = drop_sync[2] & ~drop_sync[1];

    // Left and right together cancel out
    assign press_left  = left_fall & ~right_fall;
    assign press_right = right_fall & ~left_fall;

endmodule

`default_nettype wire

// ==== design/c4_flash_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module c4_flash_display
    import c4_board_pkg::*;
#(
    parameter int flash_period = 25_000_000
)
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   game_over,
    input  board_t board,
    input  mask_t  win_mask,
    output board_t board_out
);

    localparam int CNT_BITS = (flash_period > 1) ? $clog2(flash_period) : 1;

    logic [CNT_BITS-1:0] flash_cnt;
    logic show;

    // Each show or hide phase lasts flash_period cycles
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flash_cnt <= '0;
            show      <= 1'b1;
        end
        else if (game_over)
        begin
            if (flash_cnt == CNT_BITS'(flash_period - 1))
            begin
                flash_cnt <= '0;
                show      <= ~show;
            end
            else
            begin
                flash_cnt <= flash_cnt + 1'b1;
            end
        end
    end

    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                board_out[r][c] = (win_mask[r][c] && !show) ? CELL_EMPTY : board[r][c];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/c4_game_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module c4_game_ctrl
    import c4_board_pkg::*;
    import c4_game_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                press_left,
    input  logic                press_right,
    input  logic                press_drop,
    input  logic                column_full,
    input  logic                scan_done,
    input  logic                win_found,
    output logic                place,
    output logic                scan_start,
    output logic [COL_BITS-1:0] cursor,
    output cell_t               current_player,
    output logic                game_over,
    output cell_t               winner
);

    game_state_t state;

    logic [COL_BITS-1:0] cursor_right;
    logic [COL_BITS-1:0] cursor_left;
    cell_t next_player;

    assign cursor_right = (cursor == COL_BITS'(COLS - 1)) ? '0 : cursor + 1'b1;
    assign cursor_left  = (cursor == '0) ? COL_BITS'(COLS - 1) : cursor - 1'b1;
    assign next_player  = (current_player == CELL_P1) ? CELL_P2 : CELL_P1;

    // A full column drops the request here
    assign place = (state == GS_PLACE) && !column_full;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state          <= GS_IDLE;
            scan_start     <= 1'b0;
            cursor         <= '0;
            current_player <= CELL_P1;
            game_over      <= 1'b0;
            winner         <= CELL_EMPTY;
        end
        else
        begin
            // Board is written on this edge, the scan starts the cycle after
            scan_start <= place;

            case (state)
                GS_IDLE:
                begin
                    if (press_drop)
                    begin
                        state <= GS_PLACE;
                    end
                    else if (press_right)
                    begin
                        cursor <= cursor_right;
                    end
                    else if (press_left)
                    begin
                        cursor <= cursor_left;
                    end
                end
                GS_PLACE:
                begin
                    state <= column_full ? GS_IDLE : GS_SCAN;
                end
                GS_SCAN:
                begin
                    if (scan_done)
                    begin
                        if (win_found)
                        begin
                            game_over <= 1'b1;
                            winner    <= current_player;
                            state     <= GS_OVER;
                        end
                        else
                        begin
                            current_player <= next_player;
                            state          <= GS_IDLE;
                        end
                    end
                end
                // Game ends here until the next reset
                GS_OVER:
                begin
                    state <= GS_OVER;
                end
                default:
                begin
                    state <= GS_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/connect_four_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module connect_four_top
    import c4_board_pkg::*;
#(
    parameter int flash_period = 25_000_000
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                move_left,
    input  logic                move_right,
    input  logic                drop_piece,
    output board_t              board_out,
    output logic [COL_BITS-1:0] cursor,
    output cell_t               current_player,
    output logic                game_over,
    output cell_t               winner
);

    logic press_left;
    logic press_right;
    logic press_drop;

    logic place;
    logic scan_start;
    logic scan_done;
    logic win_found;
    logic column_full;
    logic [ROW_BITS-1:0] last_row;

    logic mark;
    mask_t mark_cells;
    mask_t win_mask;
    board_t board;

    c4_button_edge u_buttons (
        .clk         (clk),
        .rst_n       (rst_n),
        .move_left   (move_left),
        .move_right  (move_right),
        .drop_piece  (drop_piece),
        .press_left  (press_left),
        .press_right (press_right),
        .press_drop  (press_drop)
    );

    c4_game_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .press_left     (press_left),
        .press_right    (press_right),
        .press_drop     (press_drop),
        .column_full    (column_full),
        .scan_done      (scan_done),
        .win_found      (win_found),
        .place          (place),
        .scan_start     (scan_start),
        .cursor         (cursor),
        .current_player (current_player),
        .game_over      (game_over),
        .winner         (winner)
    );

    c4_board_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .place       (place),
        .cursor      (cursor),
        .player      (current_player),
        .mark        (mark),
        .mark_cells  (mark_cells),
        .column_full (column_full),
        .last_row    (last_row),
        .board       (board),
        .win_mask    (win_mask)
    );

    c4_win_scan u_scan (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_start (scan_start),
        .board      (board),
        .last_row   (last_row),
        .cursor     (cursor),
        .scan_done  (scan_done),
        .win_found  (win_found),
        .mark       (mark),
        .mark_cells (mark_cells)
    );

    c4_flash_display #(
        .flash_period (flash_period)
    ) u_display (
        .clk       (clk),
        .rst_n     (rst_n),
        .game_over (game_over),
        .board     (board),
        .win_mask  (win_mask),
        .board_out (board_out)
    );

endmodule

`default_nettype wire

// ==== test/c4_ctrl_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module c4_ctrl_chk
    import c4_board_pkg::*;
    import c4_game_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic                place,
    input logic                scan_start,
    input logic [COL_BITS-1:0] cursor,
    input logic                game_over,
    input cell_t               winner,
    input game_state_t         state
);

    // Only a reset ends a finished game
    game_over_held: assert property (@(posedge clk) disable iff (!rst_n)
        game_over |=> game_over)
        else $error("game_over fell without a reset");

    winner_matches_over: assert property (@(posedge clk) disable iff (!rst_n)
        (winner != CELL_EMPTY) == game_over)
        else $error("winner and game_over disagree");

    // Cursor stays on the board and only moves while idle
    cursor_on_board: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(cursor) < COLS) && ($stable(cursor) || $past(state) == GS_IDLE))
        else $error("cursor left the board or moved outside idle");

    // A placement leads into a scan, a refused drop back to idle
    place_then_scan: assert property (@(posedge clk) disable iff (!rst_n)
        state == GS_PLACE |=> ($past(place) ? (scan_start && state == GS_SCAN)
                                           : (!scan_start && state == GS_IDLE)))
        else $error("placement was not followed by a scan start or a return to idle");

endmodule

bind c4_game_ctrl c4_ctrl_chk chk0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .place      (place),
    .scan_start (scan_start),
    .cursor     (cursor),
    .game_over  (game_over),
    .winner     (winner),
    .state      (state)
);

`default_nettype wire

// ==== test/tb_connect_four.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_connect_four
    import c4_board_pkg::*;
();

    localparam int flash_period = 6;
    localparam int drop_wait = 40;
    // About 50 drops of at most 80 cycles each, with a fivefold margin
    localparam int cycle_limit = 50 * 80 * 5;

    logic clk;
    logic rst_n;
    logic move_left;
    logic move_right;
    logic drop_piece;
    board_t board_out;
    logic [COL_BITS-1:0] cursor;
    cell_t current_player;
    logic game_over;
    cell_t winner;

    int err_count;
    int cycle_count;

    // Reference model of the game
    cell_t ref_board [ROWS][COLS];
    logic ref_mask [ROWS][COLS];
    int ref_level [COLS];
    int ref_cursor;
    cell_t ref_player;
    logic ref_over;
    cell_t ref_winner;

    connect_four_top #(
        .flash_period (flash_period)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .move_left      (move_left),
        .move_right     (move_right),
        .drop_piece     (drop_piece),
        .board_out      (board_out),
        .cursor         (cursor),
        .current_player (current_player),
        .game_over      (game_over),
        .winner         (winner)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Summary: %0d errors", err_count + 1);
            $display("Errors found");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input int exp_val, input int got_val);
        $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, what, exp_val, got_val);
        err_count++;
    endtask

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic press_button(input int which);
        case (which)
            0: move_left = 1'b0;
            1: move_right = 1'b0;
            default: drop_piece = 1'b0;
        endcase
        repeat (3) next_cycle();
        move_left  = 1'b1;
        move_right = 1'b1;
        drop_piece = 1'b1;
        repeat (3) next_cycle();
    endtask

    task automatic check_board();
        logic ok_cell;
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                // Winning cells may be in their blank phase
                ok_cell = (board_out[r][c] == ref_board[r][c]) ||
                          (ref_over && ref_mask[r][c] && board_out[r][c] == CELL_EMPTY);
                if (!ok_cell)
                begin
                    report_mismatch($sformatf("cell row %0d col %0d", r, c),
                                    int'(ref_board[r][c]), int'(board_out[r][c]));
                end
            end
        end
    endtask

    task automatic check_status();
        if (int'(cursor) != ref_cursor)
            report_mismatch("cursor", ref_cursor, int'(cursor));
        if (current_player != ref_player)
            report_mismatch("current_player", int'(ref_player), int'(current_player));
        if (game_over != ref_over)
            report_mismatch("game_over", int'(ref_over), int'(game_over));
        if (winner != ref_winner)
            report_mismatch("winner", int'(ref_winner), int'(winner));
    endtask

    task automatic reset_dut();
        rst_n      = 1'b0;
        move_left  = 1'b1;
        move_right = 1'b1;
        drop_piece = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                ref_board[r][c] = CELL_EMPTY;
                ref_mask[r][c]  = 1'b0;
            end
        end
        for (int c = 0; c < COLS; c++)
            ref_level[c] = 0;
        ref_cursor = 0;
        ref_player = CELL_P1;
        ref_over   = 1'b0;
        ref_winner = CELL_EMPTY;
        check_board();
        check_status();
    endtask

    task automatic move_cursor(input int dir);
        press_button(dir > 0 ? 1 : 0);
        if (!ref_over)
            ref_cursor = (ref_cursor + dir + COLS) % COLS;
        if (int'(cursor) != ref_cursor)
            report_mismatch("cursor after move", ref_cursor, int'(cursor));
    endtask

    task automatic goto_column(input int col);
        int steps;
        steps = (col - ref_cursor + COLS) % COLS;
        repeat (steps) move_cursor(1);
    endtask

    // Matching pieces next to (r, c) in one direction, at most three
    function automatic int run_length(int r, int c, int dr, int dc, cell_t who);
        int n;
        int rr;
        int cc;
        n  = 0;
        rr = r + dr;
        cc = c + dc;
        while (n < WIN_LEN - 1 && rr >= 0 && rr < ROWS && cc >= 0 && cc < COLS &&
               ref_board[rr][cc] == who)
        begin
            n++;
            rr += dr;
            cc += dc;
        end
        return n;
    endfunction

    task automatic model_win(input int r, input int c);
        int dr;
        int dc;
        int fwd;
        int bwd;
        cell_t who;
        who = ref_board[r][c];
        // Row, column, rising and falling diagonal
        for (int d = 0; d < 4; d++)
        begin
            dr  = (d == 0) ? 0 : 1;
            dc  = (d == 1) ? 0 : ((d == 2) ? 1 : -1);
            fwd = run_length(r, c, dr, dc, who);
            bwd = run_length(r, c, -dr, -dc, who);
            if (fwd + bwd + 1 >= WIN_LEN)
            begin
                ref_over   = 1'b1;
                ref_winner = who;
                for (int k = -bwd; k <= fwd; k++)
                    ref_mask[r + k * dr][c + k * dc] = 1'b1;
            end
        end
    endtask

    task automatic drop_at(input int col);
        cell_t prev_player;
        int row;
        int waited;
        logic expect_change;
        goto_column(col);
        prev_player   = current_player;
        expect_change = !ref_over && ref_level[ref_cursor] < ROWS;
        press_button(2);
        if (expect_change)
        begin
            row = ref_level[ref_cursor];
            ref_board[row][ref_cursor] = ref_player;
            ref_level[ref_cursor]++;
            model_win(row, ref_cursor);
            if (!ref_over)
                ref_player = (ref_player == CELL_P1) ? CELL_P2 : CELL_P1;
            waited = 0;
            while (current_player == prev_player && !game_over && waited < drop_wait)
            begin
                next_cycle();
                waited++;
            end
            if (waited >= drop_wait)
            begin
                $display("ERROR at %0t ns: no response to drop in column %0d", $time, col);
                err_count++;
            end
        end
        else
        begin
            // Nothing may change, so let more than a full scan go by
            repeat (drop_wait / 2) next_cycle();
        end
        check_board();
        check_status();
    endtask

    task automatic check_flash();
        int mr;
        int mc;
        int waited;
        logic hidden;
        cell_t exp_cell;
        mr = -1;
        mc = -1;
        for (int r = 0; r < ROWS; r++)
            for (int c = 0; c < COLS; c++)
                if (ref_mask[r][c])
                begin
                    mr = r;
                    mc = c;
                end
        if (mr < 0 || !game_over)
        begin
            $display("ERROR at %0t ns: flash test needs a finished game", $time);
            err_count++;
            return;
        end
        // Line up with the first cycle of a blank phase
        waited = 0;
        while (board_out[mr][mc] == CELL_EMPTY && waited < 3 * flash_period)
        begin
            next_cycle();
            waited++;
        end
        waited = 0;
        while (board_out[mr][mc] != CELL_EMPTY && waited < 3 * flash_period)
        begin
            next_cycle();
            waited++;
        end
        if (board_out[mr][mc] != CELL_EMPTY)
        begin
            $display("ERROR at %0t ns: winning cells never went blank", $time);
            err_count++;
        end
        for (int k = 0; k < 6 * flash_period; k++)
        begin
            hidden = ((k / flash_period) % 2) == 0;
            for (int r = 0; r < ROWS; r++)
            begin
                for (int c = 0; c < COLS; c++)
                begin
                    exp_cell = (ref_mask[r][c] && hidden) ? CELL_EMPTY : ref_board[r][c];
                    if (board_out[r][c] != exp_cell)
                        report_mismatch($sformatf("flash cell row %0d col %0d", r, c),
                                        int'(exp_cell), int'(board_out[r][c]));
                end
            end
            next_cycle();
        end
    endtask

    task automatic test_reset_cursor();
        reset_dut();
        repeat (COLS) move_cursor(1);
        if (cursor != '0)
            report_mismatch("cursor after full wrap", 0, int'(cursor));
        move_cursor(-1);
        if (int'(cursor) != COLS - 1)
            report_mismatch("cursor after left from 0", COLS - 1, int'(cursor));
    endtask

    task automatic test_stacking();
        reset_dut();
        // The ninth drop finds the column full
        repeat (ROWS + 1) drop_at(0);
    endtask

    task automatic test_vertical_win();
        reset_dut();
        drop_at(2);
        drop_at(5);
        drop_at(2);
        drop_at(5);
        drop_at(2);
        drop_at(6);
        drop_at(2);
        if (!game_over || winner != CELL_P1)
            report_mismatch("vertical winner", int'(CELL_P1), int'(winner));
        move_cursor(1);
        move_cursor(-1);
        drop_at(4);
        check_flash();
    endtask

    task automatic test_horizontal_win();
        reset_dut();
        drop_at(2);
        drop_at(2);
        drop_at(3);
        drop_at(3);
        drop_at(5);
        drop_at(5);
        // Player 2 holds a broken three on row 1
        if (game_over)
            report_mismatch("game_over on broken line", 0, 1);
        drop_at(4);
        if (!game_over || winner != CELL_P1)
            report_mismatch("horizontal winner", int'(CELL_P1), int'(winner));
    endtask

    task automatic test_diagonal_win();
        reset_dut();
        drop_at(0);
        drop_at(1);
        drop_at(1);
        drop_at(2);
        drop_at(3);
        drop_at(2);
        drop_at(2);
        drop_at(3);
        drop_at(6);
        drop_at(3);
        drop_at(3);
        if (!game_over || winner != CELL_P1)
            report_mismatch("diagonal winner", int'(CELL_P1), int'(winner));
    endtask

    initial
    begin
        err_count   = 0;
        cycle_count = 0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        move_left   = 1'b1;
        move_right  = 1'b1;
        drop_piece  = 1'b1;

        test_reset_cursor();
        test_stacking();
        test_vertical_win();
        test_horizontal_win();
        test_diagonal_win();

        $display("Summary: %0d errors", err_count);
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== win_check/c4_win_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module c4_win_scan
    import c4_board_pkg::*;
    import c4_game_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                scan_start,
    input  board_t              board,
    input  logic [ROW_BITS-1:0] last_row,
    input  logic [COL_BITS-1:0] cursor,
    output logic                scan_done,
    output logic                win_found,
    output logic                mark,
    output mask_t               mark_cells
);

    scan_win_t win_idx;
    logic active;
    logic win_flag;

    cell_t piece;
    logic win_fits;
    logic win_match;
    mask_t win_cells;
    logic hit;

    assign piece = board[last_row][cursor];

    // Walk the four cells of the current window from its lower end
    always_comb
    begin
        int dr;
        int dc;
        int back;
        int rr;
        int cc;

        dr   = 0;
        dc   = 1;
        back = 0;
        case (win_idx)
            SW_DOWN:
            begin
                dr = 1;
                dc = 0;
            end
            SW_RISE_1, SW_RISE_2, SW_RISE_3, SW_RISE_4: dr = 1;
            SW_FALL_1, SW_FALL_2, SW_FALL_3, SW_FALL_4: dr = -1;
            default: dr = 0;
        endcase

        // How many steps the line starts behind the new piece
        case (win_idx)
            SW_DOWN, SW_ROW_4, SW_RISE_4, SW_FALL_4: back = 3;
            SW_ROW_3, SW_RISE_3, SW_FALL_3: back = 2;
            SW_ROW_2, SW_RISE_2, SW_FALL_2: back = 1;
            default: back = 0;
        endcase

        win_fits  = 1'b1;
        win_match = 1'b1;
        win_cells = '0;
        for (int i = 0; i < WIN_LEN; i++)
        begin
            rr = int'(last_row) + (i - back) * dr;
            cc = int'(cursor) + (i - back) * dc;
            if (rr < 0 || rr >= ROWS || cc < 0 || cc >= COLS)
            begin
                win_fits = 1'b0;
            end
            else
            begin
                win_cells[rr][cc] = 1'b1;
                if (board[rr][cc] != piece)
                begin
                    win_match = 1'b0;
                end
            end
        end
    end

    assign hit = active & win_fits & win_match;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active   <= 1'b0;
            win_idx  <= SW_DOWN;
            win_flag <= 1'b0;
        end
        else if (scan_start)
        begin
            active   <= 1'b1;
            win_idx  <= SW_DOWN;
            win_flag <= 1'b0;
        end
        else if (active)
        begin
            if (hit)
            begin
                win_flag <= 1'b1;
            end
            if (win_idx == SW_FALL_4)
            begin
                active <= 1'b0;
            end
            else
            begin
                win_idx <= scan_win_t'(win_idx + 4'd1);
            end
        end
    end

    // Last window counts toward the result in its own cycle
    assign scan_done  = active && (win_idx == SW_FALL_4);
    assign win_found  = win_flag | hit;
    assign mark       = hit;
    assign mark_cells = win_cells;

endmodule

`default_nettype wire
